//--- src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// lookup address split from the top bit down is tag, set index and line offset
`define DC_TAG_W 20
`define DC_INDEX_W 6
`define DC_OFFSET_W 6

// cache geometry
`define DC_WAYS 4
`define DC_SETS 64

`endif

//--- src/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] addr_t; // byte address
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_WAYS-1:0] way_vec_t; // one bit per way

    typedef struct packed {
        logic  valid; // one-cycle strobe per lookup
        addr_t addr;
    } lookup_req_t;

    typedef struct packed {
        logic     valid;
        addr_t    addr;       // address of the lookup this result belongs to
        way_vec_t hit_way;    // one-hot when the lookup hits
        logic     hit;
        way_vec_t victim;     // round-robin choice for the set
        tag_t     victim_tag;
        logic     victim_vld;
    } lookup_res_t;

    typedef struct packed {
        logic     valid;
        addr_t    addr;
        way_vec_t way;        // one-hot way to be written
    } refill_t;

endpackage

`default_nettype wire

//--- src/tagv_ram.sv
`default_nettype none

`include "dcache_params.svh"

module tagv_ram (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire dcache_pkg::index_t waddr,
    input  wire dcache_pkg::index_t raddr,
    input  wire dcache_pkg::tag_t   wtag,
    input  wire logic              we,
    output dcache_pkg::tag_t        rtag,
    output logic                   rvld
);

    dcache_pkg::tag_t       tags [`DC_SETS];
    logic [`DC_SETS-1:0]    vld;

    always_ff @(posedge clk) begin
        if (we) begin
            tags[waddr] <= wtag;
        end
        rtag <= tags[raddr]; // old tag comes back on a same-cycle write
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld  <= '0; // all lines invalid after reset
            rvld <= 1'b0;
        end else begin
            rvld <= vld[raddr];
            if (we) begin
                vld[waddr] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/tagv_array.sv
`default_nettype none

`include "dcache_params.svh"

module tagv_array (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire dcache_pkg::index_t    raddr,
    input  wire dcache_pkg::tag_t      req_tag,
    input  wire dcache_pkg::refill_t   refill,
    input  wire dcache_pkg::way_vec_t  victim,
    output dcache_pkg::way_vec_t       hit,
    output logic                      cache_hit,
    output dcache_pkg::tag_t           victim_tag,
    output logic                      victim_vld
);

    dcache_pkg::tag_t     refill_tag;
    dcache_pkg::index_t   refill_index;
    dcache_pkg::tag_t     rtag [`DC_WAYS];
    logic [`DC_WAYS-1:0]  rvld;

    assign refill_tag   = refill.addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
    assign refill_index = refill.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        tagv_ram u_ram (
            .clk   (clk),
            .rst   (rst),
            .waddr (refill_index),
            .raddr (raddr),
            .wtag  (refill_tag),
            .we    (refill.valid && refill.way[w]),
            .rtag  (rtag[w]),
            .rvld  (rvld[w])
        );

        assign hit[w] = rvld[w] && (rtag[w] == req_tag); // an invalid line never hits
    end

    assign cache_hit = |hit;

    // victim contents go out to the controller for write-back and refill
    always_comb begin
        victim_tag = '0;
        victim_vld = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (victim == dcache_pkg::way_vec_t'(1 << w)) begin
                victim_tag = rtag[w];
                victim_vld = rvld[w];
            end
        end
    end // a vector that is not one-hot leaves both at zero

endmodule

`default_nettype wire

//--- src/victim_select.sv
`default_nettype none

`include "dcache_params.svh"

module victim_select (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire dcache_pkg::index_t   rindex,
    input  wire dcache_pkg::refill_t  refill,
    output dcache_pkg::way_vec_t      victim
);

    localparam int PTR_W = $clog2(`DC_WAYS);

    logic [PTR_W-1:0]    ptr [`DC_SETS];
    dcache_pkg::index_t  refill_index;
    dcache_pkg::index_t  last_index;
    logic                last_vld;
    logic [PTR_W-1:0]    rd_ptr;

    assign refill_index = refill.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                ptr[s] <= '0; // every set starts at way 0
            end
            last_vld <= 1'b0;
        end else begin
            if (refill.valid) begin
                ptr[refill_index] <= ptr[refill_index] + 1'b1; // wraps 3 -> 0
            end
            last_vld <= refill.valid;
        end
    end

    always_ff @(posedge clk) begin
        last_index <= refill_index;
    end

    // the lookup now in stage 1 was strobed together with the last refill
    // when that refill hit the same set, step back to the pointer it saw
    always_comb begin
        rd_ptr = ptr[rindex];
        if (last_vld && (last_index == rindex)) begin
            rd_ptr = rd_ptr - 1'b1;
        end
    end

    assign victim = dcache_pkg::way_vec_t'(1) << rd_ptr;

endmodule

`default_nettype wire

//--- src/dcache_tag_pipe.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_tag_pipe (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire dcache_pkg::lookup_req_t  lookup,
    input  wire dcache_pkg::refill_t      refill,
    output dcache_pkg::lookup_res_t       result
);

    dcache_pkg::lookup_req_t  s1_req;
    dcache_pkg::lookup_res_t  s2_res;
    dcache_pkg::lookup_res_t  res_d;
    dcache_pkg::index_t       raw_index;
    dcache_pkg::index_t       s1_index;
    dcache_pkg::tag_t         s1_tag;
    dcache_pkg::way_vec_t     hit_way;
    dcache_pkg::way_vec_t     victim;
    dcache_pkg::tag_t         victim_tag;
    logic                     cache_hit;
    logic                     victim_vld;

    assign raw_index = lookup.addr[`DC_OFFSET_W +: `DC_INDEX_W]; // straight to the RAM reads
    assign s1_index  = s1_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign s1_tag    = s1_req.addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];

    // stage 1 lines up with the RAM read data
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_req.valid <= 1'b0;
        end else begin
            s1_req.valid <= lookup.valid;
        end
        s1_req.addr <= lookup.addr;
    end

    tagv_array u_array (
        .clk        (clk),
        .rst        (rst),
        .raddr      (raw_index),
        .req_tag    (s1_tag),
        .refill     (refill),
        .victim     (victim),
        .hit        (hit_way),
        .cache_hit  (cache_hit),
        .victim_tag (victim_tag),
        .victim_vld (victim_vld)
    );

    victim_select u_victim (
        .clk    (clk),
        .rst    (rst),
        .rindex (s1_index),
        .refill (refill),
        .victim (victim)
    );

    always_comb begin
        res_d.valid      = s1_req.valid;
        res_d.addr       = s1_req.addr;
        res_d.hit_way    = hit_way;
        res_d.hit        = cache_hit;
        res_d.victim     = victim;
        res_d.victim_tag = victim_tag;
        res_d.victim_vld = victim_vld;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_res.valid <= 1'b0;
        end else begin
            s2_res.valid <= res_d.valid; // one-cycle pulse two edges after the strobe
        end
        s2_res.addr       <= res_d.addr;
        s2_res.hit_way    <= res_d.hit_way;
        s2_res.hit        <= res_d.hit;
        s2_res.victim     <= res_d.victim;
        s2_res.victim_tag <= res_d.victim_tag;
        s2_res.victim_vld <= res_d.victim_vld;
    end

    assign result = s2_res;

endmodule

`default_nettype wire

//--- tests/dcache_checker.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_checker (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire dcache_pkg::lookup_req_t lookup,
    input  wire dcache_pkg::refill_t     refill,
    input  wire dcache_pkg::lookup_res_t result,
    output int                           checks,
    output int                           errors,
    output int                           pending
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PTR_W = $clog2(`DC_WAYS);

    typedef struct packed {
        dcache_pkg::lookup_res_t want;
        int                      cyc;    // cycle count at the strobe edge
    } pend_t;

    dcache_pkg::tag_t  model_tag [`DC_WAYS][`DC_SETS];
    logic              model_vld [`DC_WAYS][`DC_SETS];
    logic [PTR_W-1:0]  model_ptr [`DC_SETS];
    pend_t             inflight [$];
    int                cycle;

    // prediction from the model state as it stands when the lookup is strobed
    function automatic dcache_pkg::lookup_res_t expect_result(input dcache_pkg::addr_t addr);
        dcache_pkg::lookup_res_t res;
        dcache_pkg::tag_t        tag;
        dcache_pkg::index_t      set;
        logic [PTR_W-1:0]        vw;
        tag = addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
        set = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        vw  = model_ptr[set];
        res = '0;
        res.valid = 1'b1;
        res.addr  = addr;
        for (int w = 0; w < `DC_WAYS; w++) begin
            res.hit_way[w] = model_vld[w][set] && (model_tag[w][set] == tag);
        end
        res.hit        = |res.hit_way;
        res.victim     = dcache_pkg::way_vec_t'(1) << vw;
        res.victim_tag = model_tag[vw][set];
        res.victim_vld = model_vld[vw][set];
        return res;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want_val,
                               input logic [31:0] got_val);
        checks++;
        if (got_val !== want_val) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, want_val, got_val);
            errors++;
        end
    endtask

    // lookups and refills take effect at the rising edge that samples their strobe
    always @(posedge clk) begin
        pend_t              entry;
        dcache_pkg::index_t rset;
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                model_ptr[s] = '0;
                for (int w = 0; w < `DC_WAYS; w++) begin
                    model_vld[w][s] = 1'b0;
                end
            end
            inflight.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (lookup.valid) begin
                entry.want = expect_result(lookup.addr); // before the refill below lands
                entry.cyc  = cycle;
                inflight.push_back(entry);
            end
            if (refill.valid) begin
                rset = refill.addr[`DC_OFFSET_W +: `DC_INDEX_W];
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (refill.way[w]) begin
                        model_tag[w][rset] = refill.addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
                        model_vld[w][rset] = 1'b1;
                    end
                end
                model_ptr[rset] = PTR_W'((int'(model_ptr[rset]) + 1) % `DC_WAYS);
            end
        end
    end

    // a result is due one cycle after its lookup left stage 1
    always @(negedge clk) begin
        pend_t front;
        if (!rst) begin
            if (result.valid) begin
                if (inflight.size() == 0) begin
                    $display("ERROR t=%0t: result valid with no lookup outstanding", $time);
                    errors++;
                end else begin
                    front = inflight.pop_front();
                    if (cycle - front.cyc != 1) begin
                        $display("ERROR t=%0t: result for %h came %0d cycles after its strobe",
                                 $time, front.want.addr, cycle - front.cyc + 1);
                        errors++;
                    end
                    check_field("result.addr", front.want.addr, result.addr);
                    check_field("result.hit_way", 32'(front.want.hit_way), 32'(result.hit_way));
                    check_field("result.hit", 32'(front.want.hit), 32'(result.hit));
                    check_field("result.victim", 32'(front.want.victim), 32'(result.victim));
                    check_field("result.victim_vld", 32'(front.want.victim_vld),
                                32'(result.victim_vld));
                    if (front.want.victim_vld) begin // an empty way holds no tag worth checking
                        check_field("result.victim_tag", 32'(front.want.victim_tag),
                                    32'(result.victim_tag));
                    end
                end
            end else if (inflight.size() != 0 && cycle - inflight[0].cyc >= 1) begin
                front = inflight.pop_front();
                $display("ERROR t=%0t: no result came back for the lookup of %h",
                         $time, front.want.addr);
                errors++;
            end
        end
        pending = inflight.size();
    end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
`default_nettype none

`include "dcache_params.svh"

module tb_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    logic                     clk;
    logic                     rst;
    dcache_pkg::lookup_req_t  lookup;
    dcache_pkg::refill_t      refill;
    dcache_pkg::lookup_res_t  result;
    int                       checks;
    int                       errors;
    int                       pending;
    int                       test_errors;
    logic                     timed_out;
    dcache_pkg::tag_t         pool [4];

    dcache_tag_pipe UUT (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup),
        .refill (refill),
        .result (result)
    );

    dcache_checker u_check (
        .clk     (clk),
        .rst     (rst),
        .lookup  (lookup),
        .refill  (refill),
        .result  (result),
        .checks  (checks),
        .errors  (errors),
        .pending (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        return $urandom % n;
    endfunction

    function automatic dcache_pkg::tag_t pool_tag();
        logic [1:0] k;
        k = 2'(pick(4));
        return pool[k];
    endfunction

    // the offset plays no part in the lookup so any byte of the line will do
    function automatic dcache_pkg::addr_t line_addr(input dcache_pkg::tag_t tag,
                                                    input dcache_pkg::index_t set);
        logic [`DC_OFFSET_W-1:0] off;
        off = `DC_OFFSET_W'(pick(1 << `DC_OFFSET_W));
        return {tag, set, off};
    endfunction

    task automatic drive_cycle(input logic lv, input dcache_pkg::addr_t la, input logic rv,
                               input dcache_pkg::addr_t ra, input dcache_pkg::way_vec_t rw);
        @(negedge clk);
        lookup.valid = lv;
        lookup.addr  = la;
        refill.valid = rv;
        refill.addr  = ra;
        refill.way   = rw;
    endtask

    task automatic issue_lookup(input dcache_pkg::addr_t a);
        drive_cycle(1'b1, a, 1'b0, '0, '0);
    endtask

    task automatic issue_refill(input dcache_pkg::addr_t a, input dcache_pkg::way_vec_t w);
        drive_cycle(1'b0, '0, 1'b1, a, w);
    endtask

    // go idle, let the pipeline empty, then report the test
    task automatic finish_test(input string name);
        int n;
        drive_cycle(1'b0, '0, 1'b0, '0, '0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (pending != 0 && n < 20);
        if (pending != 0) begin
            $display("timeout: %0d lookups still waiting for a result in test %s", pending, name);
            timed_out = 1'b1;
        end else begin
            $display("test %s done, %0d errors", name, errors - test_errors);
            test_errors = errors;
        end
    endtask

    initial begin
        void'($urandom(53498));
        lookup = '0;
        refill = '0;
        rst = 1'b1;
        test_errors = 0;
        timed_out = 1'b0;
        pool[0] = 20'hA0001;
        pool[1] = 20'hB0002;
        pool[2] = 20'hC0003;
        pool[3] = 20'hD0004;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 16; i++) begin
            issue_lookup(dcache_pkg::addr_t'($urandom));
        end
        finish_test("1 reset misses");

        issue_refill(line_addr(pool[0], 6'd5), 4'b0001);
        issue_refill(line_addr(pool[1], 6'd5), 4'b0010);
        issue_lookup(line_addr(pool[0], 6'd5));
        issue_lookup(line_addr(pool[1], 6'd5));
        issue_lookup(line_addr(pool[2], 6'd5)); // never written so it must miss
        finish_test("2 two ways hit");

        issue_lookup(line_addr(20'h30000, 6'd9));
        for (int i = 0; i < 5; i++) begin
            issue_refill(line_addr(dcache_pkg::tag_t'(20'h30000 + i), 6'd9),
                         dcache_pkg::way_vec_t'(1) << (i % 4));
            issue_lookup(line_addr(dcache_pkg::tag_t'(20'h30000 + i), 6'd9));
        end
        finish_test("3 round-robin victim");

        for (int i = 0; i < 24; i++) begin
            case (pick(4))
                0:       issue_lookup(line_addr(pool[0], 6'd5));
                1:       issue_lookup(line_addr(pool[1], 6'd5));
                2:       issue_lookup(line_addr(20'h30004, 6'd9));
                default: issue_lookup(dcache_pkg::addr_t'($urandom));
            endcase
        end
        finish_test("4 back-to-back lookups");

        issue_refill(line_addr(pool[2], 6'd20), 4'b0001);
        drive_cycle(1'b1, line_addr(pool[3], 6'd20), 1'b1, line_addr(pool[3], 6'd20), 4'b0010);
        issue_lookup(line_addr(pool[3], 6'd20)); // now sees the refill from the cycle before
        finish_test("5 refill collision");

        for (int i = 0; i < 2000; i++) begin
            drive_cycle(pick(4) != 0, line_addr(pool_tag(), dcache_pkg::index_t'(pick(8))),
                        pick(4) == 0, line_addr(pool_tag(), dcache_pkg::index_t'(pick(8))),
                        dcache_pkg::way_vec_t'(1) << pick(4));
        end
        finish_test("6 random mix");

        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/dcache_pkg.sv
src/tagv_ram.sv
src/tagv_array.sv
src/victim_select.sv
src/dcache_tag_pipe.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_dcache \
		-f tb.f -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
